/* hw/rv_mem_pkg.sv */
/* widths, funct3 load/store codes and the write-back record of the MEM/WB end.
   rv32 only; stores decode funct3[1:0], loads decode all three bits */
`default_nettype none

package rv_mem_pkg;

	// ------------------------------------------------------------------
	// widths
	// ------------------------------------------------------------------
	localparam int XLEN     = 32;                 // data and address width
	localparam int NUM_REGS = 32;                 // integer register file
	localparam int REG_AW   = $clog2(NUM_REGS);   // 5 bit register index

	// ------------------------------------------------------------------
	// funct3 codes of the load/store instructions
	// ------------------------------------------------------------------
	localparam logic [2:0] F3_B  = 3'b000;    // lb / sb
	localparam logic [2:0] F3_H  = 3'b001;    // lh / sh
	localparam logic [2:0] F3_W  = 3'b010;    // lw / sw
	localparam logic [2:0] F3_BU = 3'b100;    // lbu
	localparam logic [2:0] F3_HU = 3'b101;    // lhu

	// ------------------------------------------------------------------
	// write-back record, 71 bits
	// ------------------------------------------------------------------
	// One record leaves the memory stage for every accepted request,
	// stores included. Only valid and reg_write carry meaning after
	// reset; the other fields are don't-care while valid is low.
	typedef struct packed {
		logic              valid;        // record present this cycle
		logic              reg_write;    // write final_out to rd
		logic [REG_AW-1:0] rd;           // destination register
		logic [XLEN-1:0]   pc;           // pc of the instruction
		logic [XLEN-1:0]   final_out;    // load data or alu result
	} wback_state_t;

endpackage

`default_nettype wire

/* hw/mem_req_if.sv */
/* one memory-stage request; valid is a single-cycle strobe with no handshake,
   all other fields are don't-care while valid is low */
`timescale 1ns/10ps
`default_nettype none

interface mem_req_if;

	logic                             valid;         // one-cycle strobe
	logic                             is_store;      // store request
	logic                             mem_to_reg;    // load, take ram data
	logic                             reg_write;     // writes rd
	logic [rv_mem_pkg::REG_AW-1:0]    rd;            // destination reg
	logic [2:0]                       funct3;        // access width and sign
	logic [rv_mem_pkg::XLEN-1:0]      pc;
	logic [rv_mem_pkg::XLEN-1:0]      alu_out;       // address or alu result
	logic [rv_mem_pkg::XLEN-1:0]      store_data;    // rs2 value for stores

	// previous stage side
	modport drv (output valid, is_store, mem_to_reg, reg_write, rd, funct3,
		pc, alu_out, store_data);

	// memory stage side
	modport stage (input valid, is_store, mem_to_reg, reg_write, rd, funct3,
		pc, alu_out, store_data);

endinterface

`default_nettype wire

/* hw/dmem_byte_ram.sv */
/* single-port word RAM, byte write enables, one cycle read latency.
   read returns the word as it was before the same edge's write */
`timescale 1ns/10ps
`default_nettype none

module dmem_byte_ram #(
	parameter int  DEPTH = 1024,               // words
	localparam int AW    = $clog2(DEPTH)
) (
	input  wire logic                          i_clk,
	input  wire logic [AW-1:0]                 i_addr,      // word address
	input  wire logic [rv_mem_pkg::XLEN-1:0]   i_wdata,     // lane aligned
	input  wire logic [3:0]                    i_byte_en,   // one per lane
	output logic      [rv_mem_pkg::XLEN-1:0]   o_rdata
);

	// ------------------------------------------------------------------
	// storage
	// ------------------------------------------------------------------
	logic [rv_mem_pkg::XLEN-1:0] mem [DEPTH];    // no reset, payload only

	// per-lane write, lane b holds bits 8b+7..8b
	always_ff @(posedge i_clk) begin
		for (int b = 0; b < 4; b++) begin
			if (i_byte_en[b]) begin
				mem[i_addr][8*b +: 8] <= i_wdata[8*b +: 8];
			end
		end
	end

	// ------------------------------------------------------------------
	// registered read
	// ------------------------------------------------------------------
	// Updated every cycle whether or not a load is in flight; the stage
	// only looks at it one cycle after a load request.
	always_ff @(posedge i_clk) begin
		o_rdata <= mem[i_addr];                  // old data on same-edge write
	end

endmodule

`default_nettype wire

/* hw/store_align.sv */
/* places store data into its byte lanes and builds the byte enables.
   aligned accesses only: halfwords use offset bit 1, words ignore the offset */
`timescale 1ns/10ps
`default_nettype none

module store_align (
	input  wire logic [2:0]                    i_funct3,      // only [1:0] used
	input  wire logic [1:0]                    i_byte_off,    // address [1:0]
	input  wire logic [rv_mem_pkg::XLEN-1:0]   i_store_data,
	output logic      [rv_mem_pkg::XLEN-1:0]   o_wdata,
	output logic      [3:0]                    o_byte_en
);

	// ------------------------------------------------------------------
	// lane replication
	// ------------------------------------------------------------------
	// The low byte or halfword is copied to every lane so the enables
	// alone decide which lane lands in the RAM; no shifter needed.
	always_comb begin
		case (i_funct3[1:0])
			rv_mem_pkg::F3_B[1:0]: begin
				o_wdata = {4{i_store_data[7:0]}};      // sb
			end
			rv_mem_pkg::F3_H[1:0]: begin
				o_wdata = {2{i_store_data[15:0]}};     // sh
			end
			default: begin
				o_wdata = i_store_data;                // sw, unused code
			end
		endcase
	end

	// ------------------------------------------------------------------
	// byte enables
	// ------------------------------------------------------------------
	always_comb begin
		case (i_funct3[1:0])
			rv_mem_pkg::F3_B[1:0]: begin
				o_byte_en = 4'b0001 << i_byte_off;     // one hot
			end
			rv_mem_pkg::F3_H[1:0]: begin
				o_byte_en = i_byte_off[1] ? 4'b1100 : 4'b0011;
			end
			rv_mem_pkg::F3_W[1:0]: begin
				o_byte_en = 4'b1111;
			end
			default: begin
				o_byte_en = 4'b0000;                   // 2'b11 is no store
			end
		endcase
	end

endmodule

`default_nettype wire

/* hw/load_extract.sv */
/* picks the addressed byte or halfword out of a RAM word and extends it.
   aligned loads only; unknown funct3 codes pass the word through */
`timescale 1ns/10ps
`default_nettype none

module load_extract (
	input  wire logic [2:0]                    i_funct3,
	input  wire logic [1:0]                    i_byte_off,    // address [1:0]
	input  wire logic [rv_mem_pkg::XLEN-1:0]   i_rdata,       // raw ram word
	output logic      [rv_mem_pkg::XLEN-1:0]   o_load_data
);

	logic [7:0]  byte_lane;      // selected byte
	logic [15:0] half_lane;      // selected halfword

	// ------------------------------------------------------------------
	// lane select
	// ------------------------------------------------------------------
	always_comb begin
		case (i_byte_off)
			2'd0: byte_lane = i_rdata[7:0];
			2'd1: byte_lane = i_rdata[15:8];
			2'd2: byte_lane = i_rdata[23:16];
			default: byte_lane = i_rdata[31:24];
		endcase
	end

	// bit 0 of the offset ignored, misaligned halfwords not supported
	assign half_lane = i_byte_off[1] ? i_rdata[31:16] : i_rdata[15:0];

	// ------------------------------------------------------------------
	// extension by funct3
	// ------------------------------------------------------------------
	always_comb begin
		case (i_funct3)
			rv_mem_pkg::F3_B: begin
				o_load_data = {{24{byte_lane[7]}}, byte_lane};      // lb
			end
			rv_mem_pkg::F3_H: begin
				o_load_data = {{16{half_lane[15]}}, half_lane};     // lh
			end
			rv_mem_pkg::F3_BU: begin
				o_load_data = {24'b0, byte_lane};                   // lbu
			end
			rv_mem_pkg::F3_HU: begin
				o_load_data = {16'b0, half_lane};                   // lhu
			end
			default: begin
				o_load_data = i_rdata;                              // lw
			end
		endcase
	end

endmodule

`default_nettype wire

/* hw/dmem_state.sv */
/* memory stage: request at edge k, ram data and request copy at k, record at k+1.
   no stall or back-pressure; one request per cycle, two in flight */
`timescale 1ns/10ps
`default_nettype none

module dmem_state #(
	parameter int  DMEM_WORDS = 1024,
	localparam int DMEM_AW    = $clog2(DMEM_WORDS)
) (
	input  wire logic                 i_clk,
	input  wire logic                 i_reset,
	mem_req_if.stage                  i_req,
	output rv_mem_pkg::wback_state_t  o_wback_state
);

	logic [rv_mem_pkg::XLEN-1:0]   st_wdata;       // lane replicated
	logic [3:0]                    st_byte_en;     // from funct3 and offset
	logic [3:0]                    ram_byte_en;    // gated by valid store
	logic [rv_mem_pkg::XLEN-1:0]   ram_rdata;
	logic [rv_mem_pkg::XLEN-1:0]   ld_data;        // extended load value

	// request copy held while the ram read is in flight
	logic                          s1_valid;
	logic                          s1_mem_to_reg;
	logic                          s1_reg_write;
	logic [rv_mem_pkg::REG_AW-1:0] s1_rd;
	logic [rv_mem_pkg::XLEN-1:0]   s1_pc;
	logic [rv_mem_pkg::XLEN-1:0]   s1_alu_out;
	logic [2:0]                    s1_funct3;
	logic [1:0]                    s1_byte_off;

	// ------------------------------------------------------------------
	// request side, ram access at edge k
	// ------------------------------------------------------------------
	store_align u_store_align (
		.i_funct3     (i_req.funct3),
		.i_byte_off   (i_req.alu_out[1:0]),
		.i_store_data (i_req.store_data),
		.o_wdata      (st_wdata),
		.o_byte_en    (st_byte_en)
	);

	assign ram_byte_en = (i_req.valid && i_req.is_store) ? st_byte_en : 4'b0000;

	dmem_byte_ram #(.DEPTH(DMEM_WORDS)) u_ram (
		.i_clk     (i_clk),
		.i_addr    (i_req.alu_out[DMEM_AW+1:2]),    // word address
		.i_wdata   (st_wdata),
		.i_byte_en (ram_byte_en),
		.o_rdata   (ram_rdata)
	);

	always_ff @(posedge i_clk) begin
		if (i_reset) begin
			s1_valid     <= 1'b0;
			s1_reg_write <= 1'b0;
		end else begin
			s1_valid     <= i_req.valid;
			s1_reg_write <= i_req.reg_write;
		end
		s1_mem_to_reg <= i_req.mem_to_reg;            // payload, no reset
		s1_rd         <= i_req.rd;
		s1_pc         <= i_req.pc;
		s1_alu_out    <= i_req.alu_out;
		s1_funct3     <= i_req.funct3;
		s1_byte_off   <= i_req.alu_out[1:0];
	end

	// ------------------------------------------------------------------
	// load extract and record register at edge k+1
	// ------------------------------------------------------------------
	load_extract u_load_extract (
		.i_funct3    (s1_funct3),
		.i_byte_off  (s1_byte_off),
		.i_rdata     (ram_rdata),
		.o_load_data (ld_data)
	);

	always_ff @(posedge i_clk) begin
		if (i_reset) begin
			o_wback_state.valid     <= 1'b0;
			o_wback_state.reg_write <= 1'b0;
		end else begin
			o_wback_state.valid     <= s1_valid;
			o_wback_state.reg_write <= s1_valid & s1_reg_write;  // idle slot never writes
		end
		o_wback_state.rd        <= s1_rd;
		o_wback_state.pc        <= s1_pc;
		o_wback_state.final_out <= s1_mem_to_reg ? ld_data : s1_alu_out;
	end

endmodule

`default_nettype wire

/* hw/wb_regfile.sv */
/* 32 x 32 register file written from the write-back record, one async read port.
   x0 reads zero; no write-to-read bypass */
`timescale 1ns/10ps
`default_nettype none

module wb_regfile (
	input  wire logic                          i_clk,
	input  wire logic                          i_reset,
	input  wire rv_mem_pkg::wback_state_t      i_wback_state,
	input  wire logic [rv_mem_pkg::REG_AW-1:0] i_rs,
	output logic      [rv_mem_pkg::XLEN-1:0]   o_rs_data
);

	logic [rv_mem_pkg::XLEN-1:0] regs [rv_mem_pkg::NUM_REGS];
	logic                        wr_en;      // qualified write strobe

	// ------------------------------------------------------------------
	// write port
	// ------------------------------------------------------------------
	assign wr_en = i_wback_state.valid && i_wback_state.reg_write &&
		(i_wback_state.rd != '0);                // x0 never written

	always_ff @(posedge i_clk) begin
		if (i_reset) begin
			for (int r = 0; r < rv_mem_pkg::NUM_REGS; r++) begin
				regs[r] <= '0;                       // architectural clear
			end
		end else if (wr_en) begin
			regs[i_wback_state.rd] <= i_wback_state.final_out;
		end
	end

	// ------------------------------------------------------------------
	// read port
	// ------------------------------------------------------------------
	// combinational, so a value written at an edge is visible right after it
	always_comb begin
		if (i_rs == '0) begin
			o_rs_data = '0;                          // hardwired zero
		end else begin
			o_rs_data = regs[i_rs];
		end
	end

endmodule

`default_nettype wire

/* hw/mem_wb_top.sv */
/* MEM/WB top: request at edge k, o_wb_* registered at k+1, regfile write at k+2.
   no stall input; debug read port is combinational */
`timescale 1ns/10ps
`default_nettype none

module mem_wb_top #(
	parameter int DMEM_WORDS = 1024                     // data ram depth, words
) (
	input  wire logic                          i_clk,
	input  wire logic                          i_reset,
	// request from the previous stage
	input  wire logic                          i_valid,
	input  wire logic                          i_is_store,
	input  wire logic                          i_mem_to_reg,
	input  wire logic                          i_reg_write,
	input  wire logic [rv_mem_pkg::REG_AW-1:0] i_rd,
	input  wire logic [2:0]                    i_funct3,
	input  wire logic [rv_mem_pkg::XLEN-1:0]   i_pc,
	input  wire logic [rv_mem_pkg::XLEN-1:0]   i_alu_out,
	input  wire logic [rv_mem_pkg::XLEN-1:0]   i_store_data,
	input  wire logic [rv_mem_pkg::REG_AW-1:0] i_dbg_rs,
	// write-back record and debug read
	output logic                               o_wb_valid,
	output logic                               o_wb_reg_write,
	output logic      [rv_mem_pkg::REG_AW-1:0] o_wb_rd,
	output logic      [rv_mem_pkg::XLEN-1:0]   o_wb_pc,
	output logic      [rv_mem_pkg::XLEN-1:0]   o_wb_data,
	output logic      [rv_mem_pkg::XLEN-1:0]   o_dbg_rs_data
);

	mem_req_if                req();           // bundled request
	rv_mem_pkg::wback_state_t wback;           // stage to regfile record

	// ------------------------------------------------------------------
	// plain ports onto the request bundle
	// ------------------------------------------------------------------
	assign req.valid      = i_valid;
	assign req.is_store   = i_is_store;
	assign req.mem_to_reg = i_mem_to_reg;
	assign req.reg_write  = i_reg_write;
	assign req.rd         = i_rd;
	assign req.funct3     = i_funct3;
	assign req.pc         = i_pc;
	assign req.alu_out    = i_alu_out;
	assign req.store_data = i_store_data;

	dmem_state #(.DMEM_WORDS(DMEM_WORDS)) u_dmem_state (
		.i_clk         (i_clk),
		.i_reset       (i_reset),
		.i_req         (req.stage),
		.o_wback_state (wback)
	);

	wb_regfile u_wb_regfile (
		.i_clk         (i_clk),
		.i_reset       (i_reset),
		.i_wback_state (wback),
		.i_rs          (i_dbg_rs),
		.o_rs_data     (o_dbg_rs_data)
	);

	// record broken out to the plain outputs
	assign o_wb_valid     = wback.valid;
	assign o_wb_reg_write = wback.reg_write;
	assign o_wb_rd        = wback.rd;
	assign o_wb_pc        = wback.pc;
	assign o_wb_data      = wback.final_out;

endmodule

`default_nettype wire

/* sim/tb_clock.sv */
/* testbench clock and synchronous reset source.
   reset is released on a falling edge, away from the DUT's sampling edge */
`timescale 1ns/10ps
`default_nettype none

module tb_clock #(
	parameter int PERIOD       = 40,      // ns
	parameter int RESET_CYCLES = 4        // rising edges held in reset
) (
	output logic o_clk,
	output logic o_reset
);

	initial begin
		o_clk   = 1'b0;
		o_reset = 1'b1;
		repeat (RESET_CYCLES) @(posedge o_clk);
		@(negedge o_clk);                 // release between edges
		o_reset = 1'b0;
	end

	always #(PERIOD/2) o_clk = ~o_clk;

endmodule

`default_nettype wire

/* sim/tb_mem_wb.sv */
/* testbench for mem_wb_top. inputs change on falling edges, records are checked
   on falling edges against a model; random loads stay inside an initialized region */
`timescale 1ns/10ps
`default_nettype none

module tb_mem_wb;

	localparam int DMEM_WORDS  = 1024;
	localparam int DMEM_AW     = $clog2(DMEM_WORDS);
	localparam int N_RANDOM    = 200;
	localparam int N_REQUESTS  = 49 + 16 + N_RANDOM;         // directed, region fill, random
	localparam int N_READBACKS = 22 + rv_mem_pkg::NUM_REGS;
	// one cycle per request or readback, doubled, plus reset and drains
	localparam int CYCLE_LIMIT = 2 * (N_REQUESTS + N_READBACKS) + 100;

	typedef struct packed {
		int          due;                 // cycle count at which the record shows
		logic        reg_write;
		logic [4:0]  rd;
		logic [31:0] pc;
		logic [31:0] data;
	} exp_rec_t;

	logic clk, rst;
	logic valid, is_store, mem_to_reg, reg_write;
	logic [4:0] rd, dbg_rs, wb_rd;
	logic [2:0] funct3;
	logic [31:0] pc, alu_out, store_data, wb_pc, wb_data, dbg_rs_data;
	logic wb_valid, wb_reg_write;

	logic [31:0] model_mem [DMEM_WORDS];                 // reference data memory
	logic [31:0] model_regs [rv_mem_pkg::NUM_REGS];      // reference register file
	exp_rec_t    exp_buf [N_REQUESTS];                   // expected records, in order
	int exp_wr = 0, exp_rd = 0;                          // stimulus writes, checker reads
	int cyc = 0;
	int stim_checks = 0, stim_errors = 0, rec_checks = 0, rec_errors = 0;
	logic [15:0] lfsr = 16'd47;
	logic [31:0] pc_next = 32'h0000_1000;
	logic [2:0] st_tab [4] = '{rv_mem_pkg::F3_B, rv_mem_pkg::F3_H, rv_mem_pkg::F3_W,
		rv_mem_pkg::F3_W};
	logic [2:0] ld_tab [8] = '{rv_mem_pkg::F3_B, rv_mem_pkg::F3_H, rv_mem_pkg::F3_W,
		rv_mem_pkg::F3_BU, rv_mem_pkg::F3_HU, rv_mem_pkg::F3_W, rv_mem_pkg::F3_B,
		rv_mem_pkg::F3_BU};

	tb_clock #(.PERIOD(40), .RESET_CYCLES(4)) u_clock (.o_clk(clk), .o_reset(rst));

	mem_wb_top #(.DMEM_WORDS(DMEM_WORDS)) UUT (
		.i_clk(clk), .i_reset(rst), .i_valid(valid), .i_is_store(is_store),
		.i_mem_to_reg(mem_to_reg), .i_reg_write(reg_write), .i_rd(rd),
		.i_funct3(funct3), .i_pc(pc), .i_alu_out(alu_out), .i_store_data(store_data),
		.i_dbg_rs(dbg_rs), .o_wb_valid(wb_valid), .o_wb_reg_write(wb_reg_write),
		.o_wb_rd(wb_rd), .o_wb_pc(wb_pc), .o_wb_data(wb_data),
		.o_dbg_rs_data(dbg_rs_data)
	);

	// ------------------------------------------------------------------
	// reference model and random source
	// ------------------------------------------------------------------
	// fibonacci taps x^16 x^14 x^13 x^11 and one step per bit taken
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		logic        fb;
		v = '0;
		for (int i = 0; i < n; i++) begin
			fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
			lfsr = {lfsr[14:0], fb};
			v    = {v[30:0], fb};
		end
		return v;
	endfunction

	// applies one request to the model and returns the expected record data
	function automatic logic [31:0] model_request(input logic st, ld, we,
		input logic [4:0] dst, input logic [2:0] f3, input logic [31:0] addr, sdata);
		logic [DMEM_AW-1:0] widx;
		logic [31:0]        word, result;
		logic [7:0]         lane_b;
		logic [15:0]        lane_h;
		widx   = addr[DMEM_AW+1:2];
		word   = model_mem[widx];
		result = addr;                                   // alu result or address
		if (st) begin
			case (f3[1:0])
				2'b00: word[8*addr[1:0] +: 8] = sdata[7:0];
				2'b01: word[16*addr[1] +: 16] = sdata[15:0];
				2'b10: word = sdata;
				default: ;
			endcase
			model_mem[widx] = word;
		end
		if (ld) begin
			lane_b = word[8*addr[1:0] +: 8];
			lane_h = word[16*addr[1] +: 16];
			case (f3)
				rv_mem_pkg::F3_B:  result = {{24{lane_b[7]}}, lane_b};
				rv_mem_pkg::F3_H:  result = {{16{lane_h[15]}}, lane_h};
				rv_mem_pkg::F3_BU: result = {24'h0, lane_b};
				rv_mem_pkg::F3_HU: result = {16'h0, lane_h};
				default:           result = word;
			endcase
		end
		if (we && dst != 5'd0) begin
			model_regs[dst] = result;                    // x0 stays zero
		end
		return result;
	endfunction

	// ------------------------------------------------------------------
	// record checker and cycle limit
	// ------------------------------------------------------------------
	always @(negedge clk) begin : compare_records
		exp_rec_t e;
		if (!rst && wb_valid) begin
			if (exp_rd == exp_wr) begin
				rec_errors++;
				$display("Error at %0t: write-back record with no request behind it", $time);
			end else begin
				e = exp_buf[exp_rd];
				exp_rd++;
				rec_checks += 5;
				if (cyc != e.due) begin
					rec_errors++;
					$display("Error at %0t: record of pc %h came in cycle %0d, not %0d",
						$time, e.pc, cyc, e.due);
				end
				if (wb_reg_write !== e.reg_write) begin
					rec_errors++;
					$display("Mismatch at %0t: o_wb_reg_write expected %b got %b",
						$time, e.reg_write, wb_reg_write);
				end
				if (wb_rd !== e.rd) begin
					rec_errors++;
					$display("Mismatch at %0t: o_wb_rd expected %0d got %0d", $time, e.rd, wb_rd);
				end
				if (wb_pc !== e.pc) begin
					rec_errors++;
					$display("Mismatch at %0t: o_wb_pc expected %h got %h", $time, e.pc, wb_pc);
				end
				if (wb_data !== e.data) begin
					rec_errors++;
					$display("Mismatch at %0t: o_wb_data expected %h got %h",
						$time, e.data, wb_data);
				end
			end
		end else if (!rst && exp_rd != exp_wr && exp_buf[exp_rd].due <= cyc) begin
			rec_errors++;                                // overdue record dropped
			$display("Error at %0t: no record for pc %h", $time, exp_buf[exp_rd].pc);
			exp_rd++;
		end
	end

	always @(posedge clk) begin
		cyc <= cyc + 1;
		if (cyc >= CYCLE_LIMIT) begin
			$display("Error at %0t: run did not finish within %0d cycles", $time, CYCLE_LIMIT);
			$display("*** FAILED ***");
			$finish;
		end
	end

	// ------------------------------------------------------------------
	// stimulus tasks
	// ------------------------------------------------------------------
	task automatic issue(input logic st, ld, we, input logic [4:0] dst,
		input logic [2:0] f3, input logic [31:0] alu, sdata);
		exp_rec_t e;
		@(negedge clk);
		valid      = 1'b1;
		is_store   = st;
		mem_to_reg = ld;
		reg_write  = we;
		rd         = dst;
		funct3     = f3;
		pc         = pc_next;
		alu_out    = alu;
		store_data = sdata;
		e.due       = cyc + 2;                           // sampled next edge and recorded one later
		e.reg_write = we;
		e.rd        = dst;
		e.pc        = pc_next;
		e.data      = model_request(st, ld, we, dst, f3, alu, sdata);
		exp_buf[exp_wr] = e;
		exp_wr++;
		pc_next = pc_next + 32'd4;
	endtask

	task automatic store(input logic [2:0] f3, input logic [31:0] addr, sdata);
		issue(1'b1, 1'b0, 1'b0, 5'd0, f3, addr, sdata);
	endtask

	task automatic load(input logic [2:0] f3, input logic [31:0] addr, input logic [4:0] dst);
		issue(1'b0, 1'b1, 1'b1, dst, f3, addr, 32'h0);
	endtask

	// go idle and wait for every record plus one edge for the regfile write
	task automatic drain();
		@(negedge clk);
		valid = 1'b0;
		while (exp_rd != exp_wr) @(negedge clk);
		@(negedge clk);
	endtask

	task automatic check_reg(input logic [4:0] r);
		dbg_rs = r;
		@(negedge clk);
		stim_checks++;
		if (dbg_rs_data !== model_regs[r]) begin
			stim_errors++;
			$display("Mismatch at %0t: o_dbg_rs_data x%0d expected %h got %h",
				$time, r, model_regs[r], dbg_rs_data);
		end
	endtask

	task automatic random_request();
		logic [31:0] code, word, off, val, dst, we;
		logic [2:0]  f3;
		code = rand_bits(5);
		word = rand_bits(4);
		off  = rand_bits(2);
		val  = rand_bits(32);
		dst  = rand_bits(5);
		we   = rand_bits(1);
		f3   = (code[4:3] == 2'd1) ? ld_tab[code[2:0]] : st_tab[code[1:0]];
		if (f3[1:0] == 2'b01) begin
			off[0] = 1'b0;                               // aligned halfword
		end else if (f3[1:0] == 2'b10) begin
			off[1:0] = 2'b00;
		end
		case (code[4:3])
			2'd0: store(f3, 32'h100 + {26'h0, word[3:0], off[1:0]}, val);
			2'd1: load(f3, 32'h100 + {26'h0, word[3:0], off[1:0]}, dst[4:0]);
			default: issue(1'b0, 1'b0, we[0], dst[4:0], f3, val, 32'h0);
		endcase
	endtask

	task automatic report_test(input int num, input string name, input int base);
		int n;
		n = stim_errors + rec_errors - base;
		if (n == 0) begin
			$display("test %0d %s: ok", num, name);
		end else begin
			$display("test %0d %s: %0d errors", num, name, n);
		end
	endtask

	// ------------------------------------------------------------------
	// test sequence
	// ------------------------------------------------------------------
	initial begin
		int base;
		{valid, is_store, mem_to_reg, reg_write} = 4'b0;
		{rd, dbg_rs, funct3} = '0;
		{pc, alu_out, store_data} = '0;
		for (int r = 0; r < rv_mem_pkg::NUM_REGS; r++) model_regs[r] = '0;
		@(negedge rst);
		stim_checks++;
		if (wb_valid !== 1'b0 || wb_reg_write !== 1'b0) begin
			stim_errors++;
			$display("Error at %0t: write-back record not cleared by reset", $time);
		end

		base = stim_errors + rec_errors;                 // word store, word load
		store(rv_mem_pkg::F3_W, 32'h40, 32'hDEAD_BEEF);
		load(rv_mem_pkg::F3_W, 32'h40, 5'd5);
		drain();
		check_reg(5'd5);
		report_test(1, "word store/load", base);

		base = stim_errors + rec_errors;
		for (int l = 0; l < 4; l++) begin
			store(rv_mem_pkg::F3_W, 32'h80 + 4*l, 32'h1122_3344);
			store(rv_mem_pkg::F3_B, 32'h80 + 5*l, 32'hA5 + l);    // lane l of word l
			load(rv_mem_pkg::F3_W, 32'h80 + 4*l, 5'(10 + l));
		end
		for (int h = 0; h < 2; h++) begin
			store(rv_mem_pkg::F3_W, 32'hA0 + 4*h, 32'h5566_7788);
			store(rv_mem_pkg::F3_H, 32'hA0 + 6*h, 32'hBEEF_C0DE);
			load(rv_mem_pkg::F3_W, 32'hA0 + 4*h, 5'(14 + h));
		end
		drain();
		for (int r = 10; r < 16; r++) check_reg(5'(r));
		report_test(2, "byte and halfword stores", base);

		base = stim_errors + rec_errors;
		store(rv_mem_pkg::F3_W, 32'hC0, 32'hF081_92A3);              // every lane negative
		store(rv_mem_pkg::F3_W, 32'hC4, 32'h7F01_5A3C);              // every lane positive
		for (int w = 0; w < 2; w++) begin
			for (int l = 0; l < 4; l++) load(rv_mem_pkg::F3_B, 32'hC0 + 4*w + l, 5'(16 + l));
			load(rv_mem_pkg::F3_H, 32'hC0 + 4*w, 5'd20);
			load(rv_mem_pkg::F3_H, 32'hC2 + 4*w, 5'd21);
		end
		drain();
		for (int r = 16; r < 22; r++) check_reg(5'(r));
		report_test(3, "signed loads", base);

		base = stim_errors + rec_errors;
		for (int w = 0; w < 2; w++) begin
			for (int l = 0; l < 4; l++) load(rv_mem_pkg::F3_BU, 32'hC0 + 4*w + l, 5'(22 + l));
			load(rv_mem_pkg::F3_HU, 32'hC0 + 4*w, 5'd26);
			load(rv_mem_pkg::F3_HU, 32'hC2 + 4*w, 5'd27);
		end
		drain();
		for (int r = 22; r < 28; r++) check_reg(5'(r));
		report_test(4, "unsigned loads", base);

		base = stim_errors + rec_errors;
		issue(1'b0, 1'b0, 1'b1, 5'd7, 3'b000, 32'h1234_5678, 32'h0);
		issue(1'b0, 1'b0, 1'b0, 5'd8, 3'b000, 32'hCAFE_F00D, 32'h0);  // no write enable
		issue(1'b0, 1'b0, 1'b1, 5'd0, 3'b000, 32'hFFFF_FFFF, 32'h0);  // x0 target
		drain();
		check_reg(5'd7);
		check_reg(5'd8);
		check_reg(5'd0);
		report_test(5, "alu write-back and x0", base);

		base = stim_errors + rec_errors;
		for (int w = 0; w < 16; w++) store(rv_mem_pkg::F3_W, 32'h100 + 4*w, rand_bits(32));
		for (int i = 0; i < N_RANDOM; i++) random_request();
		drain();
		for (int r = 0; r < rv_mem_pkg::NUM_REGS; r++) check_reg(5'(r));
		report_test(6, "random back-to-back mix", base);

		$display("%0d checks, %0d errors", stim_checks + rec_checks, stim_errors + rec_errors);
		if (stim_errors + rec_errors == 0) begin
			$display("*** PASSED ***");
		end else begin
			$display("*** FAILED ***");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* vlog.f */
hw/rv_mem_pkg.sv
hw/mem_req_if.sv
hw/dmem_byte_ram.sv
hw/store_align.sv
hw/load_extract.sv
hw/dmem_state.sv
hw/wb_regfile.sv
hw/mem_wb_top.sv
sim/tb_clock.sv
sim/tb_mem_wb.sv

/* run_sim.sh */
#!/bin/sh
# Builds the MEM/WB testbench with Verilator, runs it and checks the log.
cd "$(dirname "$0")" || exit 1

TOP=tb_mem_wb
LOG=sim.log

verilator --binary --timing --top-module "$TOP" -f vlog.f -Mdir obj_dir -o "$TOP"
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/"$TOP" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q '\*\*\* FAILED \*\*\*' "$LOG"; then
	echo "result: fail"
	exit 1
fi
if ! grep -q '\*\*\* PASSED \*\*\*' "$LOG"; then
	echo "result: no pass line in $LOG"
	exit 1
fi
echo "result: pass"
exit 0
